//--- Makefile
# Verilator build and run for the tape loader testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- src/download_writer.sv
// Host download writer: toggle requests to the tape store, wait level, tape length
`include "tape_defs.svh"

module download_writer (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    ioctl_download_i,
	input  logic                    ioctl_wr_i,
	input  logic [`TAPE_ADDR_W-1:0] ioctl_addr_i,
	input  logic [`TAPE_DATA_W-1:0] ioctl_data_i,
	input  logic                    wr_ack_i,
	output tape_bus_pkg::mem_port_t wr_port_o,
	output logic                    ioctl_wait_o,
	output logic [`TAPE_ADDR_W-1:0] tape_len_o,
	output logic                    load_done_o
);
	import tape_bus_pkg::*;

	mem_req_t                wr_req_q;
	logic                    wr_tgl_q;
	logic                    dl_q;
	logic [`TAPE_ADDR_W-1:0] hi_q;

	// Latched host write, held until the arbiter takes it
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i) begin
			wr_req_q <= '{addr: ioctl_addr_i, data: ioctl_data_i, we: 1'b1};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			wr_tgl_q    <= 1'b0;
			dl_q        <= 1'b0;
			hi_q        <= '0;
			tape_len_o  <= '0;
			load_done_o <= 1'b0;
		end else begin
			dl_q        <= ioctl_download_i;
			load_done_o <= dl_q & ~ioctl_download_i;
			if (ioctl_wr_i) begin
				wr_tgl_q <= ~wr_tgl_q;
				// Track highest address written, plus one
				if (ioctl_addr_i >= hi_q) hi_q <= ioctl_addr_i + 1'b1;
			end
			// New download starts from an empty image
			if (~dl_q & ioctl_download_i) hi_q <= '0;
			if (dl_q & ~ioctl_download_i) tape_len_o <= hi_q;
		end
	end

	assign wr_port_o    = '{req: wr_req_q, tgl: wr_tgl_q};
	assign ioctl_wait_o = wr_tgl_q ^ wr_ack_i;

endmodule

//--- src/mem_arbiter.sv
// Tape store arbiter: two toggle-request peers, writer first, one access per cycle
module mem_arbiter (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  tape_bus_pkg::mem_port_t wr_port_i,
	input  tape_bus_pkg::mem_port_t rd_port_i,
	output logic                    wr_ack_o,
	output logic                    rd_ack_o,
	output tape_bus_pkg::mem_req_t  mem_req_o,
	output logic                    mem_en_o
);

	logic sel_wr_q;
	logic pend_wr;
	logic pend_rd;

	// Pending toggles, masking the peer whose access is at the store now
	assign pend_wr = (wr_port_i.tgl ^ wr_ack_o) & ~(mem_en_o & sel_wr_q);
	assign pend_rd = (rd_port_i.tgl ^ rd_ack_o) & ~(mem_en_o & ~sel_wr_q);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mem_en_o <= 1'b0;
			sel_wr_q <= 1'b0;
			wr_ack_o <= 1'b0;
			rd_ack_o <= 1'b0;
		end else begin
			// Access done at the store this edge
			if (mem_en_o) begin
				if (sel_wr_q) wr_ack_o <= ~wr_ack_o;
				else rd_ack_o <= ~rd_ack_o;
			end
			mem_en_o <= pend_wr | pend_rd;
			if (pend_wr) sel_wr_q <= 1'b1;
			else if (pend_rd) sel_wr_q <= 1'b0;
		end
	end

	// Granted request forwarded to the store
	always_ff @(posedge clk_sys) begin
		if (pend_wr) mem_req_o <= wr_port_i.req;
		else if (pend_rd) mem_req_o <= rd_port_i.req;
	end

endmodule

//--- src/tape_bus_pkg.sv
// Tape store access types: single memory request and toggle-request peer port
`include "tape_defs.svh"

package tape_bus_pkg;

	// =====================================================================
	// One access to the tape store
	// =====================================================================
	typedef struct packed {
		logic [`TAPE_ADDR_W-1:0] addr;
		logic [`TAPE_DATA_W-1:0] data;
		logic                    we;
	} mem_req_t;

	// =====================================================================
	// One peer's side of the arbiter
	// =====================================================================
	// Request is pending while tgl differs from the ack returned by the arbiter
	typedef struct packed {
		mem_req_t req;
		logic     tgl;
	} mem_port_t;

endpackage

//--- src/tape_clock_en.sv
// Tape clock-enable divider following CPU speed, with RAM wait gating
`include "tape_defs.svh"

module tape_clock_en (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  tape_ctrl_pkg::cpu_speed_t cpu_speed_i,
	input  logic                      ram_wait_i,
	output logic                      tape_ce_o
);
	import tape_ctrl_pkg::*;

	logic [`CE_DIV_W-1:0] div_q;
	cpu_speed_t           speed_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			div_q     <= '0;
			speed_q   <= SPEED_3M5;
			tape_ce_o <= 1'b0;
		end else begin
			div_q <= div_q + 1'b1;
			// Speed only changes at wrap, so no short periods
			if (&div_q) speed_q <= cpu_speed_i;
			case (speed_q)
				SPEED_3M5: tape_ce_o <= (div_q[4:0] == 5'd0);
				SPEED_7M:  tape_ce_o <= (div_q[3:0] == 4'd0);
				SPEED_14M: tape_ce_o <= (div_q[2:0] == 3'd0) & ~ram_wait_i;
				SPEED_28M: tape_ce_o <= (div_q[1:0] == 2'd0) & ~ram_wait_i;
				default:   tape_ce_o <= 1'b0;
			endcase
		end
	end

endmodule

//--- src/tape_ctrl_pkg.sv
// Transport control types: key event and CPU speed selection
package tape_ctrl_pkg;

	// Key event, accepted when stb toggles
	typedef struct packed {
		logic       stb;
		logic       pressed;
		logic [8:0] code;
	} key_evt_t;

	// CPU speed select, also sets the tape clock-enable rate
	typedef enum logic [1:0] {
		SPEED_3M5 = 2'd0,
		SPEED_7M  = 2'd1,
		SPEED_14M = 2'd2,
		SPEED_28M = 2'd3
	} cpu_speed_t;

endpackage

//--- src/tape_defs.svh
// Tape subsystem widths, key scan codes and clock-enable divider width
`ifndef TAPE_DEFS_SVH
`define TAPE_DEFS_SVH

// Tape store geometry
`define TAPE_ADDR_W 12
`define TAPE_DATA_W 8

// PS/2 scan codes in the 9-bit code field
`define KEY_F5 9'h003
`define KEY_F6 9'h00B
`define KEY_F7 9'h083

// Tape clock-enable divider
`define CE_DIV_W 5

`endif

//--- src/tape_loader_top.sv
// Tape loader top: download writer, transport, arbiter, tape store and clock-enable
`include "tape_defs.svh"

module tape_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          ioctl_download_i,
	input  logic                          ioctl_wr_i,
	input  logic [`TAPE_ADDR_W-1:0]       ioctl_addr_i,
	input  logic [`TAPE_DATA_W-1:0]       ioctl_data_i,
	input  tape_ctrl_pkg::key_evt_t       key_i,
	input  tape_ctrl_pkg::cpu_speed_t     cpu_speed_i,
	input  logic                          ram_wait_i,
	input  logic                          tzx_req_i,
	input  logic                          loop_start_i,
	input  logic                          loop_next_i,
	input  logic                          stop_i,
	output logic                          ioctl_wait_o,
	output logic                          tzx_ack_o,
	output logic [`TAPE_DATA_W-1:0]       tape_data_o,
	output logic                          motor_o,
	output logic                          tape_ready_o,
	output logic                          tape_ce_o
);
	import tape_bus_pkg::*;

	mem_port_t               wr_port;
	mem_port_t               rd_port;
	logic                    wr_ack;
	logic                    rd_ack;
	mem_req_t                mem_req;
	logic                    mem_en;
	logic [`TAPE_DATA_W-1:0] rd_data;
	logic [`TAPE_ADDR_W-1:0] tape_len;
	logic                    load_done;

	download_writer u_writer (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.wr_ack_i         (wr_ack),
		.wr_port_o        (wr_port),
		.ioctl_wait_o     (ioctl_wait_o),
		.tape_len_o       (tape_len),
		.load_done_o      (load_done)
	);

	tape_transport u_transport (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.key_i        (key_i),
		.tzx_req_i    (tzx_req_i),
		.loop_start_i (loop_start_i),
		.loop_next_i  (loop_next_i),
		.stop_i       (stop_i),
		.tape_len_i   (tape_len),
		.load_done_i  (load_done),
		.rd_ack_i     (rd_ack),
		.rd_data_i    (rd_data),
		.rd_port_o    (rd_port),
		.tzx_ack_o    (tzx_ack_o),
		.tape_data_o  (tape_data_o),
		.motor_o      (motor_o),
		.tape_ready_o (tape_ready_o)
	);

	mem_arbiter u_arbiter (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.wr_port_i (wr_port),
		.rd_port_i (rd_port),
		.wr_ack_o  (wr_ack),
		.rd_ack_o  (rd_ack),
		.mem_req_o (mem_req),
		.mem_en_o  (mem_en)
	);

	tape_store u_store (
		.clk_sys   (clk_sys),
		.mem_en_i  (mem_en),
		.mem_req_i (mem_req),
		.rd_data_o (rd_data)
	);

	tape_clock_en u_clock_en (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.cpu_speed_i (cpu_speed_i),
		.ram_wait_i  (ram_wait_i),
		.tape_ce_o   (tape_ce_o)
	);

endmodule

//--- src/tape_store.sv
// Tape image store: byte-wide synchronous RAM with registered read
`include "tape_defs.svh"

module tape_store (
	input  logic                    clk_sys,
	input  logic                    mem_en_i,
	input  tape_bus_pkg::mem_req_t  mem_req_i,
	output logic [`TAPE_DATA_W-1:0] rd_data_o
);

	localparam int DEPTH = 2 ** `TAPE_ADDR_W;

	logic [`TAPE_DATA_W-1:0] mem [DEPTH];

	// Write on an enabled write, register read data otherwise
	always_ff @(posedge clk_sys) begin
		if (mem_en_i) begin
			if (mem_req_i.we) begin
				mem[mem_req_i.addr] <= mem_req_i.data;
			end else begin
				rd_data_o <= mem[mem_req_i.addr];
			end
		end
	end

endmodule

//--- src/tape_transport.sv
// Tape transport: play/pause, ready, restart, eject, loop mark and byte fetch
`include "tape_defs.svh"

module tape_transport (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  tape_ctrl_pkg::key_evt_t key_i,
	input  logic                    tzx_req_i,
	input  logic                    loop_start_i,
	input  logic                    loop_next_i,
	input  logic                    stop_i,
	input  logic [`TAPE_ADDR_W-1:0] tape_len_i,
	input  logic                    load_done_i,
	input  logic                    rd_ack_i,
	input  logic [`TAPE_DATA_W-1:0] rd_data_i,
	output tape_bus_pkg::mem_port_t rd_port_o,
	output logic                    tzx_ack_o,
	output logic [`TAPE_DATA_W-1:0] tape_data_o,
	output logic                    motor_o,
	output logic                    tape_ready_o
);

	logic                    key_stb_q;
	logic                    req_seen_q;
	logic                    fetching_q;
	logic                    rd_tgl_q;
	logic [`TAPE_ADDR_W-1:0] rd_addr_q;
	logic [`TAPE_ADDR_W-1:0] fetch_addr_q;
	logic [`TAPE_ADDR_W-1:0] loop_mark_q;
	logic                    new_req;
	logic                    rd_done;
	logic                    key_evt;

	// Player toggled and no store read outstanding
	assign new_req = (tzx_req_i != req_seen_q) && !fetching_q;
	// Store ack caught up with our toggle
	assign rd_done = fetching_q && (rd_tgl_q == rd_ack_i);
	assign key_evt = key_i.stb != key_stb_q;

	// ======================================================================
	// Transport state and key decode
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			key_stb_q    <= 1'b0;
			req_seen_q   <= 1'b0;
			fetching_q   <= 1'b0;
			rd_tgl_q     <= 1'b0;
			tzx_ack_o    <= 1'b0;
			fetch_addr_q <= '0;
			loop_mark_q  <= '0;
			motor_o      <= 1'b0;
			tape_ready_o <= 1'b0;
		end else begin
			key_stb_q <= key_i.stb;

			if (new_req) begin
				req_seen_q   <= tzx_req_i;
				fetching_q   <= 1'b1;
				rd_tgl_q     <= ~rd_tgl_q;
				fetch_addr_q <= fetch_addr_q + 1'b1;
				// Fetch past the image, tape runs out
				if (fetch_addr_q >= tape_len_i) begin
					tape_ready_o <= 1'b0;
					motor_o      <= 1'b0;
				end
			end

			if (rd_done) begin
				fetching_q <= 1'b0;
				tzx_ack_o  <= req_seen_q;
			end

			if (loop_start_i) loop_mark_q <= fetch_addr_q;
			if (loop_next_i) fetch_addr_q <= loop_mark_q;
			if (stop_i) motor_o <= 1'b0;

			if (key_evt) begin
				if (key_i.code == `KEY_F5 && key_i.pressed) motor_o <= ~motor_o;
				// Restart rewinds and pauses
				if (key_i.code == `KEY_F6) begin
					fetch_addr_q <= '0;
					motor_o      <= 1'b0;
				end
				if (key_i.code == `KEY_F7) tape_ready_o <= 1'b0;
			end

			// No tape, no motor
			if (!tape_ready_o) motor_o <= 1'b0;

			// Fresh image, rewind and start playing
			if (load_done_i) begin
				tape_ready_o <= 1'b1;
				motor_o      <= 1'b1;
				fetch_addr_q <= '0;
			end
		end
	end

	// Read address and returned byte
	always_ff @(posedge clk_sys) begin
		if (new_req) rd_addr_q <= fetch_addr_q;
		if (rd_done) tape_data_o <= rd_data_i;
	end

	assign rd_port_o = '{req: '{addr: rd_addr_q, data: '0, we: 1'b0}, tgl: rd_tgl_q};

endmodule

//--- tb.f
+incdir+src
src/tape_bus_pkg.sv
src/tape_ctrl_pkg.sv
src/download_writer.sv
src/tape_transport.sv
src/mem_arbiter.sv
src/tape_store.sv
src/tape_clock_en.sv
src/tape_loader_top.sv
testbench/tape_properties.sv
testbench/tb_top.sv

//--- testbench/tape_properties.sv
// Bound arbiter checks: one access per cycle, acks only for pending requests, idle wait after reset
module tape_properties (
	input logic                    clk_sys,
	input logic                    RESET,
	input tape_bus_pkg::mem_port_t wr_port_i,
	input tape_bus_pkg::mem_port_t rd_port_i,
	input logic                    wr_ack_i,
	input logic                    rd_ack_i,
	input logic                    mem_en_i,
	input tape_bus_pkg::mem_req_t  mem_req_i
);

	int unsigned fail_count = 0;

	// Every ack toggle closes one store access of that peer's own kind
	wr_access_a: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(wr_ack_i) |-> $past(mem_en_i && mem_req_i.we))
		else begin
			$error("writer ack toggled without a store write");
			fail_count++;
		end

	rd_access_a: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rd_ack_i) |-> $past(mem_en_i && !mem_req_i.we))
		else begin
			$error("reader ack toggled without a store read");
			fail_count++;
		end

	wr_ack_pending_a: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(wr_ack_i) |-> $past(wr_port_i.tgl != wr_ack_i))
		else begin
			$error("writer ack toggled with no pending request");
			fail_count++;
		end

	rd_ack_pending_a: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rd_ack_i) |-> $past(rd_port_i.tgl != rd_ack_i))
		else begin
			$error("reader ack toggled with no pending request");
			fail_count++;
		end

	// Host wait level is the writer toggle mismatch
	wait_idle_a: assert property (@(posedge clk_sys)
		RESET |=> (wr_port_i.tgl == wr_ack_i))
		else begin
			$error("host wait level high right after reset");
			fail_count++;
		end

endmodule

bind mem_arbiter tape_properties u_props (
	.clk_sys   (clk_sys),
	.RESET     (RESET),
	.wr_port_i (wr_port_i),
	.rd_port_i (rd_port_i),
	.wr_ack_i  (wr_ack_o),
	.rd_ack_i  (rd_ack_o),
	.mem_en_i  (mem_en_o),
	.mem_req_i (mem_req_o)
);

//--- testbench/tb_top.sv
// Testbench top: clock, reset, seeded random stimulus, tape model, checks and watchdog
`include "tape_defs.svh"

module tb_top;
	import tape_ctrl_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int AW         = `TAPE_ADDR_W;
	localparam int DW         = `TAPE_DATA_W;
	localparam int MAX_LEN    = 80;
	localparam int HS_LIMIT   = 64;
	// Two downloads, every fetch, six clock-enable windows, in cycles
	localparam int TEST_CYCLES   = 2 * MAX_LEN * 8 + (3 * MAX_LEN + 40) * 16 + 6 * 600 + 200;
	localparam int MARGIN        = 2;
	localparam int WATCHDOG_TIME = TEST_CYCLES * MARGIN * CLK_PERIOD;

	logic          clk_sys;
	logic          RESET;
	logic          ioctl_download;
	logic          ioctl_wr;
	logic [AW-1:0] ioctl_addr;
	logic [DW-1:0] ioctl_data;
	key_evt_t      key;
	cpu_speed_t    cpu_speed;
	logic          ram_wait;
	logic          tzx_req;
	logic          loop_start;
	logic          loop_next;
	logic          stop;
	logic          ioctl_wait;
	logic          tzx_ack;
	logic [DW-1:0] tape_data;
	logic          motor;
	logic          tape_ready;
	logic          tape_ce;

	// Reference model of the tape image and transport
	logic [DW-1:0] img [2 ** AW];
	logic [AW-1:0] m_hi;
	logic [AW-1:0] m_len;
	logic [AW-1:0] m_addr;
	logic [AW-1:0] m_mark;
	logic          m_ready;
	logic          m_play;

	tape_loader_top DUT (
		.clk_sys          (clk_sys),
		.RESET            (RESET),
		.ioctl_download_i (ioctl_download),
		.ioctl_wr_i       (ioctl_wr),
		.ioctl_addr_i     (ioctl_addr),
		.ioctl_data_i     (ioctl_data),
		.key_i            (key),
		.cpu_speed_i      (cpu_speed),
		.ram_wait_i       (ram_wait),
		.tzx_req_i        (tzx_req),
		.loop_start_i     (loop_start),
		.loop_next_i      (loop_next),
		.stop_i           (stop),
		.ioctl_wait_o     (ioctl_wait),
		.tzx_ack_o        (tzx_ack),
		.tape_data_o      (tape_data),
		.motor_o          (motor),
		.tape_ready_o     (tape_ready),
		.tape_ce_o        (tape_ce)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		wait (DUT.u_arbiter.u_props.fail_count != 0);
		$display("Bound arbiter assertion failed");
		$display("Simulation FAILED");
		$fatal(1, "bound assertion failure");
	end

	// ======================================================================
	// Reporting and checks
	// ======================================================================
	task automatic fail_value(input string name, input int exp, input int act);
		$display("** Error: %s: expected %0h, actual %0h", name, exp, act);
		$display("Simulation FAILED");
		$fatal(1, "value mismatch in %s", name);
	endtask

	task automatic fail_msg(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "handshake timeout");
	endtask

	task automatic check_eq(input string name, input int exp, input int act);
		assert (exp == act) else fail_value(name, exp, act);
	endtask

	task automatic check_state(input string name);
		check_eq({name, " motor"}, int'(m_play), int'(motor));
		check_eq({name, " ready"}, int'(m_ready), int'(tape_ready));
	endtask

	// ======================================================================
	// Host download
	// ======================================================================
	task automatic wait_host_idle();
		int n;
		n = 0;
		while (ioctl_wait) begin
			@(negedge clk_sys);
			n++;
			if (n > HS_LIMIT) fail_msg("ioctl_wait stuck high during download");
		end
	endtask

	task automatic start_download();
		ioctl_download = 1'b1;
		m_hi = '0;
		@(negedge clk_sys);
	endtask

	task automatic download_bytes(input logic [AW-1:0] base, input int len);
		logic [AW-1:0] addr;
		logic [DW-1:0] data;
		for (int i = 0; i < len; i++) begin
			addr = base + AW'(i);
			data = DW'($urandom);
			wait_host_idle();
			ioctl_wr   = 1'b1;
			ioctl_addr = addr;
			ioctl_data = data;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			// Host is held off from the cycle after its strobe
			check_eq("download wait", 1, int'(ioctl_wait));
			img[addr] = data;
			if (addr >= m_hi) m_hi = addr + 1'b1;
			repeat ($urandom_range(0, 2)) @(negedge clk_sys);
		end
	endtask

	// Falling download level loads the length and starts play from 0
	task automatic end_download(input string name);
		int n;
		wait_host_idle();
		ioctl_download = 1'b0;
		n = 0;
		while (!tape_ready) begin
			@(negedge clk_sys);
			n++;
			if (n > HS_LIMIT) fail_msg("tape never became ready after download");
		end
		m_len   = m_hi;
		m_addr  = '0;
		m_ready = 1'b1;
		m_play  = 1'b1;
		check_state(name);
	endtask

	// ======================================================================
	// Player side
	// ======================================================================
	task automatic fetch(input string name, input logic check_data);
		int            n;
		logic [DW-1:0] exp;
		exp = img[m_addr];
		tzx_req = ~tzx_req;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > HS_LIMIT) fail_msg("player request never acknowledged");
		end while (tzx_ack != tzx_req);
		if (m_addr >= m_len) begin
			m_ready = 1'b0;
			m_play  = 1'b0;
		end
		m_addr = m_addr + 1'b1;
		if (check_data) check_eq(name, int'(exp), int'(tape_data));
		check_state(name);
		repeat ($urandom_range(0, 3)) @(negedge clk_sys);
	endtask

	task automatic press_key(input logic [8:0] code, input string name);
		key.code    = code;
		key.pressed = 1'b1;
		key.stb     = ~key.stb;
		repeat (2) @(negedge clk_sys);
		if (code == `KEY_F5) m_play = m_ready & ~m_play;
		if (code == `KEY_F6) begin
			m_addr = '0;
			m_play = 1'b0;
		end
		if (code == `KEY_F7) begin
			m_ready = 1'b0;
			m_play  = 1'b0;
		end
		check_state(name);
	endtask

	task automatic strobe_ctrl(input logic start, input logic next, input logic halt);
		loop_start = start;
		loop_next  = next;
		stop       = halt;
		@(negedge clk_sys);
		loop_start = 1'b0;
		loop_next  = 1'b0;
		stop       = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic count_ce(input cpu_speed_t speed, input logic wait_lvl, input int exp,
		input string name);
		int cnt;
		int tol;
		cpu_speed = speed;
		ram_wait  = wait_lvl;
		// A gated enable must stay silent, a running one may be off by one pulse
		tol = (exp == 0) ? 0 : 1;
		// Let the divider wrap so the new speed takes effect
		repeat (64) @(negedge clk_sys);
		cnt = 0;
		repeat (512) begin
			@(negedge clk_sys);
			if (tape_ce) cnt++;
		end
		assert (cnt >= exp - tol && cnt <= exp + tol) else fail_value(name, exp, cnt);
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin
		int len_a;
		int len_b;
		void'($urandom(47));
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		key            = '0;
		cpu_speed      = SPEED_3M5;
		ram_wait       = 1'b0;
		tzx_req        = 1'b0;
		loop_start     = 1'b0;
		loop_next      = 1'b0;
		stop           = 1'b0;
		m_hi           = '0;
		m_len          = '0;
		m_addr         = '0;
		m_mark         = '0;
		m_ready        = 1'b0;
		m_play         = 1'b0;
		repeat (8) @(negedge clk_sys);
		check_eq("reset wait", 0, int'(ioctl_wait));
		check_eq("reset tzx ack", int'(tzx_req), int'(tzx_ack));
		check_eq("reset tape ce", 0, int'(tape_ce));
		check_state("reset");
		RESET = 1'b0;
		@(negedge clk_sys);

		// Download and readback in address order
		len_a = $urandom_range(16, MAX_LEN);
		start_download();
		download_bytes('0, len_a);
		end_download("download");
		for (int i = 0; i < len_a; i++) fetch("readback", 1'b1);

		// One fetch past the image runs the tape out
		fetch("end of tape", 1'b0);

		// Second image appended while the player reads the first
		press_key(`KEY_F6, "rewind idle");
		len_b = $urandom_range(16, MAX_LEN);
		start_download();
		fork
			download_bytes(AW'(len_a), len_b);
			for (int i = 0; i < 8; i++) fetch("contention read", 1'b1);
		join
		end_download("contention load");
		for (int i = 0; i < len_a + len_b; i++) fetch("contention readback", 1'b1);

		// Keys
		press_key(`KEY_F5, "f5 pause");
		press_key(`KEY_F5, "f5 play");
		press_key(`KEY_F6, "f6 restart");
		fetch("f6 first byte", 1'b1);
		press_key(`KEY_F5, "f5 resume");

		// Loop mark, rewind to it, then stop
		repeat (2) fetch("loop lead-in", 1'b1);
		strobe_ctrl(1'b1, 1'b0, 1'b0);
		m_mark = m_addr;
		repeat ($urandom_range(1, 4)) fetch("loop body", 1'b1);
		strobe_ctrl(1'b0, 1'b1, 1'b0);
		m_addr = m_mark;
		fetch("loop next byte", 1'b1);
		strobe_ctrl(1'b0, 1'b0, 1'b1);
		m_play = 1'b0;
		check_state("stop");
		press_key(`KEY_F7, "f7 eject");

		// Clock enable rates, then wait gating at the fast speeds
		for (int s = 0; s < 4; s++) begin
			count_ce(cpu_speed_t'(s), 1'b0, 512 >> (5 - s), $sformatf("ce speed %0d", s));
		end
		count_ce(SPEED_14M, 1'b1, 0, "ce wait speed 2");
		count_ce(SPEED_28M, 1'b1, 0, "ce wait speed 3");

		if (DUT.u_arbiter.u_props.fail_count != 0) begin
			$display("Bound arbiter assertions failed %0d times",
				DUT.u_arbiter.u_props.fail_count);
			$display("Simulation FAILED");
			$fatal(1, "bound assertion failures");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule
